// File: hdl/fp_format_pkg.sv
package fp_format_pkg;

	// recoded single precision operand, sign on top.
	localparam int WORD_W = 33;
	localparam int EXP_W = 9;
	localparam int FRAC_W = 23;
	localparam int EXP_BIAS = 127;

	// signed exponent carried through the datapath.
	localparam int RES_EXP_W = 11;

	localparam int CLASS_W = 10;

	// one-hot class vector bit positions.
	localparam int CLS_NEG_INF = 0;
	localparam int CLS_NEG_NORM = 1;
	localparam int CLS_NEG_SUB = 2;
	localparam int CLS_NEG_ZERO = 3;
	localparam int CLS_POS_ZERO = 4;
	localparam int CLS_POS_SUB = 5;
	localparam int CLS_POS_NORM = 6;
	localparam int CLS_POS_INF = 7;
	localparam int CLS_SNAN = 8;
	localparam int CLS_QNAN = 9;

	// 1.0 in the recoded format, used as divisor for square root.
	localparam logic [WORD_W-1:0] SQRT_ONE = 33'h07F800000;

	typedef logic [WORD_W-1:0] fp_word_t;
	typedef logic [CLASS_W-1:0] fp_class_t;

endpackage

// File: hdl/fdiv_op_pkg.sv
package fdiv_op_pkg;

	localparam int QUO_W = 26;
	localparam int REM_W = 28;

	localparam int DIV_ITER = 26;
	localparam int SQRT_ITER = 25;

	typedef struct packed {
		logic snan;
		logic qnan;
		logic dbz;
		logic inf;
		logic zero;
	} fdiv_flags_t;

	// operand state handed to the recurrence.
	typedef struct packed {
		logic sign;
		logic signed [fp_format_pkg::RES_EXP_W-1:0] exp;
		logic sqrt;
		logic [REM_W-1:0] m;
		logic [REM_W-1:0] r;
	} fdiv_seed_t;

	// raw quotient and remainder for normalization.
	typedef struct packed {
		logic sign;
		logic signed [fp_format_pkg::RES_EXP_W-1:0] exp;
		logic [QUO_W-1:0] q;
		logic [REM_W-1:0] r;
	} fdiv_quo_t;

endpackage

// File: hdl/fdiv_stream_if.sv
`timescale 1ns/1ps

interface fdiv_stream_if #(
	parameter type payload_t = logic
);
	import fdiv_op_pkg::*;

	logic valid;
	logic ready;
	payload_t payload;
	fdiv_flags_t flags;

	// payload and flags are held stable until valid and ready meet.
	modport src (
		output valid,
		output payload,
		output flags,
		input ready
	);

	modport dst (
		input valid,
		input payload,
		input flags,
		output ready
	);

endinterface

// File: hdl/fdiv_unpack.sv
`timescale 1ns/1ps

module fdiv_unpack (
	input logic in_valid_i,
	output logic in_ready_o,
	input logic sqrt_i,
	input fp_format_pkg::fp_word_t a_i,
	input fp_format_pkg::fp_word_t b_i,
	input fp_format_pkg::fp_class_t class_a_i,
	input fp_format_pkg::fp_class_t class_b_i,
	fdiv_stream_if.src seed_o
);
	import fp_format_pkg::*;
	import fdiv_op_pkg::*;

	localparam int SQRT_BIAS = 2 * EXP_BIAS - 1;

	fp_word_t b;
	fp_class_t cls_b;
	logic a_zero;
	logic a_inf;
	logic a_fin;
	logic b_zero;
	logic b_inf;
	logic b_fin;
	logic signed [RES_EXP_W-1:0] a_exp;
	logic signed [RES_EXP_W-1:0] b_exp;
	logic signed [RES_EXP_W-1:0] exp_res;
	fdiv_flags_t flags;
	fdiv_seed_t seed;

	// square root divides by one.
	assign b = sqrt_i ? SQRT_ONE : b_i;
	assign cls_b = sqrt_i ? '0 : class_b_i;

	assign a_zero = class_a_i[CLS_NEG_ZERO] | class_a_i[CLS_POS_ZERO];
	assign a_inf = class_a_i[CLS_NEG_INF] | class_a_i[CLS_POS_INF];
	assign a_fin = class_a_i[CLS_NEG_NORM] | class_a_i[CLS_NEG_SUB] |
		class_a_i[CLS_POS_SUB] | class_a_i[CLS_POS_NORM];
	assign b_zero = cls_b[CLS_NEG_ZERO] | cls_b[CLS_POS_ZERO];
	assign b_inf = cls_b[CLS_NEG_INF] | cls_b[CLS_POS_INF];
	assign b_fin = cls_b[CLS_NEG_NORM] | cls_b[CLS_NEG_SUB] |
		cls_b[CLS_POS_SUB] | cls_b[CLS_POS_NORM];

	always_comb begin
		flags = '0;
		// invalid cases take priority over a quiet NaN.
		if (class_a_i[CLS_SNAN] | cls_b[CLS_SNAN]) begin
			flags.snan = 1'b1;
		end else if (a_zero & b_zero) begin
			flags.snan = 1'b1;
		end else if (a_inf & b_inf) begin
			flags.snan = 1'b1;
		end else if (class_a_i[CLS_QNAN] | cls_b[CLS_QNAN]) begin
			flags.qnan = 1'b1;
		end
		if (a_inf & (b_fin | b_zero)) begin
			flags.inf = 1'b1;
		end else if (b_zero & a_fin) begin
			flags.dbz = 1'b1;
		end
		if (a_zero | b_inf) begin
			flags.zero = 1'b1;
		end
		if (sqrt_i) begin
			if (class_a_i[CLS_POS_INF]) begin
				flags.inf = 1'b1;
			end
			// negative operands have no real root.
			if (class_a_i[CLS_NEG_INF] | class_a_i[CLS_NEG_NORM] | class_a_i[CLS_NEG_SUB]) begin
				flags.snan = 1'b1;
			end
		end
	end

	assign a_exp = {{(RES_EXP_W - EXP_W){1'b0}}, a_i[FRAC_W +: EXP_W]};
	assign b_exp = {{(RES_EXP_W - EXP_W){1'b0}}, b[FRAC_W +: EXP_W]};
	assign exp_res = sqrt_i ? (a_exp - RES_EXP_W'(SQRT_BIAS)) >>> 1 : a_exp - b_exp;

	always_comb begin
		seed.sign = a_i[WORD_W-1] ^ b[WORD_W-1];
		seed.exp = exp_res;
		seed.sqrt = sqrt_i;
		seed.m = {4'b0001, b[FRAC_W-1:0], 1'b0};
		seed.r = {5'b00001, a_i[FRAC_W-1:0]};
		if (sqrt_i) begin
			seed.m = '0;
			// odd exponent, so the radicand is doubled.
			if (!a_i[FRAC_W]) begin
				seed.r = {seed.r[REM_W-2:0], 1'b0};
			end
		end
	end

	assign seed_o.valid = in_valid_i;
	assign seed_o.payload = seed;
	assign seed_o.flags = flags;
	assign in_ready_o = seed_o.ready;

endmodule

// File: hdl/fdiv_recurrence.sv
`timescale 1ns/1ps

module fdiv_recurrence #(
	parameter int DIV_ITER = fdiv_op_pkg::DIV_ITER,
	parameter int SQRT_ITER = fdiv_op_pkg::SQRT_ITER
) (
	input logic clock,
	input logic reset,
	fdiv_stream_if.dst seed_i,
	fdiv_stream_if.src quo_o
);
	import fdiv_op_pkg::*;

	localparam int CNT_W = $clog2(DIV_ITER + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ITER,
		ST_DONE
	} state_t;

	state_t state_q;
	logic [CNT_W-1:0] count_q;
	logic [CNT_W-1:0] bit_idx;
	fdiv_seed_t op_q;
	fdiv_flags_t flags_q;
	logic [QUO_W-1:0] q_q;
	logic [REM_W-1:0] m_step;
	logic [REM_W-1:0] r_shift;
	logic [REM_W-1:0] diff;
	logic accept;

	assign accept = (state_q == ST_IDLE) & seed_i.valid;

	// count runs one above the bit being resolved.
	assign bit_idx = count_q - CNT_W'(1);

	always_comb begin
		m_step = op_q.m;
		// square root trial divisor is built from the partial root.
		if (op_q.sqrt && count_q != '0) begin
			m_step = {1'b0, q_q, 1'b0};
			m_step[bit_idx] = 1'b1;
		end
		r_shift = {op_q.r[REM_W-2:0], 1'b0};
		diff = r_shift - m_step;
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			state_q <= ST_IDLE;
			count_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (seed_i.valid) begin
						state_q <= ST_ITER;
						count_q <= seed_i.payload.sqrt ? CNT_W'(SQRT_ITER) : CNT_W'(DIV_ITER);
					end
				end
				ST_ITER: begin
					if (count_q == '0) begin
						state_q <= ST_DONE;
					end else begin
						count_q <= count_q - CNT_W'(1);
					end
				end
				ST_DONE: begin
					if (quo_o.ready) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_q <= seed_i.payload;
			flags_q <= seed_i.flags;
			q_q <= '0;
		end else if (state_q == ST_ITER && count_q != '0) begin
			q_q[bit_idx] <= ~diff[REM_W-1];
			// restore on a negative trial remainder.
			op_q.r <= diff[REM_W-1] ? r_shift : diff;
		end
	end

	assign seed_i.ready = (state_q == ST_IDLE);

	assign quo_o.valid = (state_q == ST_DONE);
	assign quo_o.payload = '{sign: op_q.sign, exp: op_q.exp, q: q_q, r: op_q.r};
	assign quo_o.flags = flags_q;

endmodule

// File: hdl/fdiv_normalize.sv
`timescale 1ns/1ps

module fdiv_normalize (
	input logic clock,
	input logic reset,
	fdiv_stream_if.dst quo_i,
	output logic out_valid_o,
	input logic out_ready_i,
	output logic sign_o,
	output logic signed [fp_format_pkg::RES_EXP_W-1:0] exp_o,
	output logic [fp_format_pkg::FRAC_W+1:0] mant_o,
	output logic [2:0] grs_o,
	output fdiv_op_pkg::fdiv_flags_t flags_o
);
	import fp_format_pkg::*;
	import fdiv_op_pkg::*;

	localparam int PAD_W = 25;
	localparam int NORM_W = QUO_W + REM_W - 1 + PAD_W;
	localparam int MAX_SHIFT = 54;
	localparam int SHIFT_W = $clog2(MAX_SHIFT + 1);

	logic lead_zero;
	logic [NORM_W-1:0] frac_shl;
	logic [NORM_W-1:0] frac_shr;
	logic signed [RES_EXP_W-1:0] exp_biased;
	logic signed [RES_EXP_W-1:0] exp_norm;
	logic [SHIFT_W-1:0] shift_amt;
	logic load;

	always_comb begin
		lead_zero = ~quo_i.payload.q[QUO_W-1];
		frac_shl = {quo_i.payload.q, quo_i.payload.r[REM_W-2:0], {PAD_W{1'b0}}};
		frac_shl = frac_shl << lead_zero;
		exp_biased = quo_i.payload.exp + RES_EXP_W'(EXP_BIAS) - RES_EXP_W'(lead_zero);
		shift_amt = '0;
		exp_norm = exp_biased;
		// subnormal result, denormalize into the zero exponent.
		if (exp_biased <= 0) begin
			shift_amt = SHIFT_W'(MAX_SHIFT);
			if (exp_biased > -MAX_SHIFT) begin
				shift_amt = SHIFT_W'(RES_EXP_W'(1) - exp_biased);
			end
			exp_norm = '0;
		end
		frac_shr = frac_shl >> shift_amt;
	end

	assign quo_i.ready = ~out_valid_o | out_ready_i;
	assign load = quo_i.valid & quo_i.ready;

	always_ff @(posedge clock) begin
		if (!reset) begin
			out_valid_o <= 1'b0;
		end else if (load) begin
			out_valid_o <= 1'b1;
		end else if (out_ready_i) begin
			out_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			sign_o <= quo_i.payload.sign;
			exp_o <= exp_norm;
			mant_o <= {1'b0, frac_shr[NORM_W-1 -: FRAC_W+1]};
			grs_o <= {frac_shr[NORM_W-FRAC_W-2 -: 2], |frac_shr[NORM_W-FRAC_W-4:0]};
			flags_o <= quo_i.flags;
		end
	end

endmodule

// File: hdl/fdiv_top.sv
`timescale 1ns/1ps

module fdiv_top #(
	parameter int DIV_ITER = fdiv_op_pkg::DIV_ITER,
	parameter int SQRT_ITER = fdiv_op_pkg::SQRT_ITER
) (
	input logic clock,
	input logic reset,
	input logic in_valid_i,
	output logic in_ready_o,
	input logic sqrt_i,
	input fp_format_pkg::fp_word_t a_i,
	input fp_format_pkg::fp_word_t b_i,
	input fp_format_pkg::fp_class_t class_a_i,
	input fp_format_pkg::fp_class_t class_b_i,
	output logic out_valid_o,
	input logic out_ready_i,
	output logic sign_o,
	output logic signed [fp_format_pkg::RES_EXP_W-1:0] exp_o,
	output logic [fp_format_pkg::FRAC_W+1:0] mant_o,
	output logic [2:0] grs_o,
	output fdiv_op_pkg::fdiv_flags_t flags_o
);
	import fdiv_op_pkg::*;

	fdiv_stream_if #(.payload_t(fdiv_seed_t)) seed_s ();
	fdiv_stream_if #(.payload_t(fdiv_quo_t)) quo_s ();

	fdiv_unpack u_unpack (
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.sqrt_i(sqrt_i),
		.a_i(a_i),
		.b_i(b_i),
		.class_a_i(class_a_i),
		.class_b_i(class_b_i),
		.seed_o(seed_s.src)
	);

	fdiv_recurrence #(
		.DIV_ITER(DIV_ITER),
		.SQRT_ITER(SQRT_ITER)
	) u_recurrence (
		.clock(clock),
		.reset(reset),
		.seed_i(seed_s.dst),
		.quo_o(quo_s.src)
	);

	fdiv_normalize u_normalize (
		.clock(clock),
		.reset(reset),
		.quo_i(quo_s.dst),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.sign_o(sign_o),
		.exp_o(exp_o),
		.mant_o(mant_o),
		.grs_o(grs_o),
		.flags_o(flags_o)
	);

endmodule

// File: tb/fdiv_vectors.svh
// columns: check_data, sqrt, a, b, class a, class b,
// then expected sign, exp, mant, grs, flags.
task automatic fill_vectors();
	// exact divides.
	vectors[0] = '{1'b1, 1'b0, 33'h080C00000, 33'h080400000, 10'h040, 10'h040,
		1'b0, 11'h080, 25'h0800000, 3'h0, 5'h00};
	vectors[1] = '{1'b1, 1'b0, 33'h080400000, 33'h080000000, 10'h040, 10'h040,
		1'b0, 11'h07F, 25'h0C00000, 3'h0, 5'h00};
	vectors[2] = '{1'b1, 1'b0, 33'h07F800000, 33'h07F800000, 10'h040, 10'h040,
		1'b0, 11'h07F, 25'h0800000, 3'h0, 5'h00};
	vectors[3] = '{1'b1, 1'b0, 33'h180C00000, 33'h080400000, 10'h002, 10'h040,
		1'b1, 11'h080, 25'h0800000, 3'h0, 5'h00};
	// one third, guard and sticky left over.
	vectors[4] = '{1'b1, 1'b0, 33'h07F800000, 33'h080400000, 10'h040, 10'h040,
		1'b0, 11'h07D, 25'h0AAAAAA, 3'h5, 5'h00};
	// square roots of 4.0 and 2.25.
	vectors[5] = '{1'b1, 1'b1, 33'h080800000, 33'h000000000, 10'h040, 10'h000,
		1'b0, 11'h080, 25'h0800000, 3'h0, 5'h00};
	vectors[6] = '{1'b1, 1'b1, 33'h080100000, 33'h000000000, 10'h040, 10'h000,
		1'b0, 11'h07F, 25'h0C00000, 3'h0, 5'h00};
	// special cases, only sign and flags are meaningful.
	vectors[7] = '{1'b0, 1'b0, 33'h000000000, 33'h000000000, 10'h010, 10'h010,
		1'b0, 11'h000, 25'h0000000, 3'h0, 5'h11};
	vectors[8] = '{1'b0, 1'b0, 33'h07F800000, 33'h000000000, 10'h040, 10'h010,
		1'b0, 11'h000, 25'h0000000, 3'h0, 5'h04};
	vectors[9] = '{1'b0, 1'b0, 33'h0E0000000, 33'h07F800000, 10'h080, 10'h040,
		1'b0, 11'h000, 25'h0000000, 3'h0, 5'h02};
	vectors[10] = '{1'b0, 1'b0, 33'h0E0400000, 33'h07F800000, 10'h200, 10'h040,
		1'b0, 11'h000, 25'h0000000, 3'h0, 5'h08};
	vectors[11] = '{1'b0, 1'b1, 33'h180800000, 33'h000000000, 10'h002, 10'h000,
		1'b1, 11'h000, 25'h0000000, 3'h0, 5'h10};
	vectors[12] = '{1'b0, 1'b1, 33'h0E0000000, 33'h000000000, 10'h080, 10'h000,
		1'b0, 11'h000, 25'h0000000, 3'h0, 5'h02};
	// smallest normal over 8.0 lands three places into the subnormal range.
	vectors[13] = '{1'b1, 1'b0, 33'h040800000, 33'h081000000, 10'h040, 10'h040,
		1'b0, 11'h000, 25'h0100000, 3'h0, 5'h00};
endtask

// File: tb/fdiv_tb.sv
`timescale 1ns/1ps

module fdiv_tb;
	import fp_format_pkg::*;

	localparam int DIV_ITER = 26;
	localparam int SQRT_ITER = 25;
	localparam int NUM_VEC = 14;
	localparam int CYCLE_LIMIT = NUM_VEC * 40 + NUM_VEC * 40 * 2;

	typedef struct packed {
		logic check_data;
		logic sqrt;
		fp_word_t a;
		fp_word_t b;
		fp_class_t cls_a;
		fp_class_t cls_b;
		logic sign;
		logic [RES_EXP_W-1:0] exp;
		logic [FRAC_W+1:0] mant;
		logic [2:0] grs;
		logic [4:0] flags;
	} vec_t;

	logic clock;
	logic reset;
	logic in_valid_i;
	logic in_ready_o;
	logic sqrt_i;
	fp_word_t a_i;
	fp_word_t b_i;
	fp_class_t class_a_i;
	fp_class_t class_b_i;
	logic out_valid_o;
	logic out_ready_i;
	logic sign_o;
	logic signed [RES_EXP_W-1:0] exp_o;
	logic [FRAC_W+1:0] mant_o;
	logic [2:0] grs_o;
	logic [4:0] flags_o;

	vec_t vectors [NUM_VEC];
	int value_errors = 0;
	int order_errors = 0;
	int cycle_count = 0;

	`include "fdiv_vectors.svh"

	fdiv_top #(
		.DIV_ITER(DIV_ITER),
		.SQRT_ITER(SQRT_ITER)
	) uut (
		.clock(clock),
		.reset(reset),
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.sqrt_i(sqrt_i),
		.a_i(a_i),
		.b_i(b_i),
		.class_a_i(class_a_i),
		.class_b_i(class_b_i),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.sign_o(sign_o),
		.exp_o(exp_o),
		.mant_o(mant_o),
		.grs_o(grs_o),
		.flags_o(flags_o)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic drive_vector(input int idx);
		in_valid_i = 1'b1;
		sqrt_i = vectors[idx].sqrt;
		a_i = vectors[idx].a;
		b_i = vectors[idx].b;
		class_a_i = vectors[idx].cls_a;
		class_b_i = vectors[idx].cls_b;
	endtask

	task automatic check_result(input int idx);
		assert (flags_o == vectors[idx].flags) else begin
			value_errors++;
			$display("Fail flags_o vec %0d: got %h expected %h", idx, flags_o, vectors[idx].flags);
		end
		assert (sign_o == vectors[idx].sign) else begin
			value_errors++;
			$display("Fail sign_o vec %0d: got %h expected %h", idx, sign_o, vectors[idx].sign);
		end
		if (vectors[idx].check_data) begin
			assert (exp_o == vectors[idx].exp) else begin
				value_errors++;
				$display("Fail exp_o vec %0d: got %h expected %h", idx, exp_o, vectors[idx].exp);
			end
			assert (mant_o == vectors[idx].mant) else begin
				value_errors++;
				$display("Fail mant_o vec %0d: got %h expected %h", idx, mant_o,
					vectors[idx].mant);
			end
			assert (grs_o == vectors[idx].grs) else begin
				value_errors++;
				$display("Fail grs_o vec %0d: got %h expected %h", idx, grs_o, vectors[idx].grs);
			end
		end
	endtask

	// one operation at a time, result taken at once.
	task automatic run_single(input int idx);
		int latency;
		int expected;
		expected = vectors[idx].sqrt ? SQRT_ITER + 2 : DIV_ITER + 2;
		drive_vector(idx);
		while (!in_ready_o) begin
			@(posedge clock);
			#1;
		end
		@(posedge clock);
		#1;
		in_valid_i = 1'b0;
		latency = 0;
		while (!out_valid_o) begin
			@(posedge clock);
			#1;
			latency++;
		end
		assert (latency == expected) else begin
			value_errors++;
			$display("Fail latency vec %0d: got %h expected %h", idx, latency, expected);
		end
		check_result(idx);
		// hand the result over before the next operation.
		@(posedge clock);
		#1;
	endtask

	// back to back operations with a random output ready.
	task automatic run_stream();
		int sent;
		int recv;
		logic fire_in;
		sent = 0;
		recv = 0;
		while (recv < NUM_VEC) begin
			if (sent < NUM_VEC) begin
				drive_vector(sent);
			end else begin
				in_valid_i = 1'b0;
			end
			out_ready_i = 1'($urandom);
			fire_in = in_valid_i & in_ready_o;
			if (out_valid_o && out_ready_i) begin
				check_result(recv);
				recv++;
			end
			@(posedge clock);
			#1;
			if (fire_in) begin
				sent++;
			end
			assert (sent - recv <= 2) else begin
				order_errors++;
				$display("more than two operations were accepted while a result waited");
			end
		end
		in_valid_i = 1'b0;
	endtask

	initial begin
		void'($urandom(41688));
		reset = 1'b0;
		in_valid_i = 1'b0;
		sqrt_i = 1'b0;
		a_i = '0;
		b_i = '0;
		class_a_i = '0;
		class_b_i = '0;
		out_ready_i = 1'b1;
		fill_vectors();
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b1;
		for (int i = 0; i < NUM_VEC; i++) begin
			run_single(i);
		end
		run_stream();
		$display("errors: %0d value, %0d protocol", value_errors, order_errors);
		if (value_errors + order_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+tb
hdl/fp_format_pkg.sv
hdl/fdiv_op_pkg.sv
hdl/fdiv_stream_if.sv
hdl/fdiv_unpack.sv
hdl/fdiv_recurrence.sv
hdl/fdiv_normalize.sv
hdl/fdiv_top.sv
tb/fdiv_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert
TOP      = fdiv_tb
FILELIST = flist.f
OBJ_DIR  = obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
